// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := hsid_tb
RTL_TOP    := hsid_top
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Testbench passed
VFLAGS     := --binary --timing --assert -Wno-fatal -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing
RTL_SRCS   := $(shell grep '^design/.*\.sv$$' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) +incdir+design $(RTL_SRCS)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/hsid_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hsid_macros.svh"

module hsid_apb_regs
  import hsid_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // APB3 slave
  input  logic [7:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  // Reference FIFO side
  output logic        wr_en,                 // One cycle push
  output word_t       data_in,
  output logic        loop_en_run,           // Run bit
  output logic        clear,                 // One cycle flush
  output addr_t       almost_full_threshold,
  input  logic        full,
  input  logic        almost_full,
  input  logic        empty,
  // SAD unit side
  output logic        sample_valid,          // One cycle sample strobe
  output word_t       sample,
  output cnt_t        bands,
  output sad_t        det_thresh,
  input  logic        busy,
  input  sad_t        result,
  input  logic        result_valid,
  input  logic        detect
);

  localparam cnt_t BANDS_RESET = cnt_t'(1 << `HSID_FIFO_ADDR_WIDTH); // Full spectrum

  logic        sel_ctrl;
  logic        sel_af;
  logic        sel_det;
  logic        sel_ref;
  logic        sel_pix;
  logic        sel_stat;
  logic        sel_res;
  logic        sel_bands;
  logic        mapped;
  logic        access;    // Access phase
  logic        done;      // Transfer completes this cycle
  logic        err;
  logic        wr_ok;     // Completed error free write
  logic        run;
  logic [31:0] status;

  // Address decode
  assign sel_ctrl  = (paddr == `HSID_REG_CTRL);
  assign sel_af    = (paddr == `HSID_REG_AF_THRESH);
  assign sel_det   = (paddr == `HSID_REG_DET_THRESH);
  assign sel_ref   = (paddr == `HSID_REG_REF);
  assign sel_pix   = (paddr == `HSID_REG_PIX);
  assign sel_stat  = (paddr == `HSID_REG_STATUS);
  assign sel_res   = (paddr == `HSID_REG_RESULT);
  assign sel_bands = (paddr == `HSID_REG_BANDS);
  assign mapped    = sel_ctrl | sel_af | sel_det | sel_ref | sel_pix |
                     sel_stat | sel_res | sel_bands;

  // Handshake, PIX waits while a sample is in flight
  assign access = psel && penable;
  assign pready = !(access && sel_pix && busy);
  assign done   = access && pready;

  // REF only while idle and not full, PIX only in run with a spectrum loaded
  assign err = !mapped ||
               (pwrite && sel_ref && (full || run)) ||
               (pwrite && sel_pix && (!run || empty));

  assign pslverr = done && err;
  assign wr_ok   = done && pwrite && !err;

  assign loop_en_run = run;

  // Read data
  always_comb begin
    status = '0;
    status[`HSID_STAT_EMPTY]  = empty;
    status[`HSID_STAT_AFULL]  = almost_full;
    status[`HSID_STAT_FULL]   = full;
    status[`HSID_STAT_RVALID] = result_valid;
    status[`HSID_STAT_DETECT] = detect;
  end

  always_comb begin
    prdata = '0; // Write only and unmapped read as zero
    if (sel_ctrl) begin
      prdata[1] = run; // Clear bit always reads back 0
    end else if (sel_af) begin
      prdata = 32'(almost_full_threshold);
    end else if (sel_det) begin
      prdata = 32'(det_thresh);
    end else if (sel_stat) begin
      prdata = status;
    end else if (sel_res) begin
      prdata = 32'(result);
    end else if (sel_bands) begin
      prdata = 32'(bands);
    end
  end

  // Control registers and strobes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run                   <= 1'b0;
      almost_full_threshold <= '0;
      det_thresh            <= '0;
      bands                 <= BANDS_RESET;
      wr_en                 <= 1'b0;
      sample_valid          <= 1'b0;
      clear                 <= 1'b0;
    end else begin
      wr_en        <= wr_ok && sel_ref;            // Push next cycle
      sample_valid <= wr_ok && sel_pix;            // Sample next cycle
      clear        <= wr_ok && sel_ctrl && pwdata[0]; // Self clearing
      if (wr_ok && sel_ctrl) begin
        run <= pwdata[1];
      end
      if (wr_ok && sel_af) begin
        almost_full_threshold <= pwdata[`HSID_FIFO_ADDR_WIDTH-1:0];
      end
      if (wr_ok && sel_det) begin
        det_thresh <= pwdata[`HSID_SAD_WIDTH-1:0];
      end
      if (wr_ok && sel_bands) begin
        bands <= pwdata[`HSID_FIFO_ADDR_WIDTH:0];
      end
    end
  end

  // Payload words ride alongside the strobes
  always_ff @(posedge clk) begin
    if (wr_ok && sel_ref) begin
      data_in <= pwdata[`HSID_WORD_WIDTH-1:0];
    end
    if (wr_ok && sel_pix) begin
      sample <= pwdata[`HSID_WORD_WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== design/hsid_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hsid_macros.svh"

module hsid_fifo #(
  parameter int WORD_WIDTH      = `HSID_WORD_WIDTH,      // Data word width
  parameter int FIFO_ADDR_WIDTH = `HSID_FIFO_ADDR_WIDTH  // Depth is 2**FIFO_ADDR_WIDTH
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       loop_en,               // Recirculate head to tail
  input  logic                       wr_en,
  input  logic                       rd_en,
  input  logic [WORD_WIDTH-1:0]      data_in,
  input  logic [FIFO_ADDR_WIDTH-1:0] almost_full_threshold, // Level in entries
  output logic [WORD_WIDTH-1:0]      data_out,
  output logic                       full,
  output logic                       almost_full,
  output logic                       empty,
  input  logic                       clear                  // Synchronous flush
);

  localparam int FIFO_DEPTH = 2 ** FIFO_ADDR_WIDTH;

  logic [WORD_WIDTH-1:0]      fifo_mem [FIFO_DEPTH]; // Storage
  logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;                // Tail
  logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;                // Head
  logic [FIFO_ADDR_WIDTH:0]   fifo_count;            // 0 to FIFO_DEPTH
  logic                       do_loop;
  logic                       do_rd;
  logic                       do_wr;

  // Flags come straight from the fill level
  assign empty = (fifo_count == '0);
  assign full  = (fifo_count == (FIFO_ADDR_WIDTH + 1)'(FIFO_DEPTH));

  // A zero threshold would flag an empty FIFO, so empty masks it
  assign almost_full = !empty && (fifo_count >= {1'b0, almost_full_threshold});

  // Clear wins, then loop, then plain read and write
  assign do_loop = !clear && loop_en && !empty;
  assign do_rd   = !clear && !loop_en && rd_en && !empty;
  assign do_wr   = !clear && !loop_en && wr_en && !full;

  // Pointers and fill level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
    end else if (clear) begin
      wr_ptr     <= '0; // Contents become don't care
      rd_ptr     <= '0;
      fifo_count <= '0;
    end else begin
      if (do_loop || do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_loop || do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        fifo_count <= fifo_count + 1'b1;
      end else if (do_rd && !do_wr) begin
        fifo_count <= fifo_count - 1'b1;
      end
      // Loop and read plus write keep the level
    end
  end

  // Storage and output word
  always_ff @(posedge clk) begin
    if (do_loop) begin
      data_out         <= fifo_mem[rd_ptr]; // Valid one cycle after loop_en
      fifo_mem[wr_ptr] <= fifo_mem[rd_ptr]; // Head goes back in at the tail
    end else begin
      if (do_rd) begin
        data_out <= fifo_mem[rd_ptr];
      end
      if (do_wr) begin
        fifo_mem[wr_ptr] <= data_in;
      end
    end
  end

  // When full the tail equals the head, so a loop rewrites the same slot
  // and the spectrum replays in order at any fill level

endmodule

`default_nettype wire

// ==== design/hsid_macros.svh ====
`ifndef HSID_MACROS_SVH
`define HSID_MACROS_SVH

// Datapath widths
`define HSID_WORD_WIDTH      16     // One band sample or reference word
`define HSID_FIFO_ADDR_WIDTH 4      // 16 entry reference FIFO
`define HSID_SAD_WIDTH       24     // Room for 16 bands of full scale differences

// APB register map as byte offsets
`define HSID_REG_CTRL        8'h00  // Bit 0 clear pulse, bit 1 run
`define HSID_REG_AF_THRESH   8'h04  // FIFO almost-full level in entries
`define HSID_REG_DET_THRESH  8'h08  // Detect when SAD is below this
`define HSID_REG_REF         8'h0C  // Write only, pushes one reference word
`define HSID_REG_PIX         8'h10  // Write only, one pixel band sample
`define HSID_REG_STATUS      8'h14  // Read only flags
`define HSID_REG_RESULT      8'h18  // Read only latched SAD
`define HSID_REG_BANDS       8'h1C  // Bands per pixel

// STATUS bit positions
`define HSID_STAT_EMPTY      0
`define HSID_STAT_AFULL      1
`define HSID_STAT_FULL       2
`define HSID_STAT_RVALID     3
`define HSID_STAT_DETECT     4

`endif // HSID_MACROS_SVH

// ==== design/hsid_pkg.sv ====
`default_nettype none

`include "hsid_macros.svh"

package hsid_pkg;

  // Band sample or reference spectrum word
  typedef logic [`HSID_WORD_WIDTH-1:0] word_t;

  // FIFO pointer, also used for thresholds given in entries
  typedef logic [`HSID_FIFO_ADDR_WIDTH-1:0] addr_t;

  // Fill level or band count, one bit wider so a full FIFO fits
  typedef logic [`HSID_FIFO_ADDR_WIDTH:0] cnt_t;

  // Running SAD and the latched result
  typedef logic [`HSID_SAD_WIDTH-1:0] sad_t;

  // SAD unit sequencing, three cycles per sample
  typedef enum logic [1:0] {
    SAD_IDLE  = 2'd0, // Waiting for a sample
    SAD_FETCH = 2'd1, // Loop request to the FIFO
    SAD_ACC   = 2'd2  // Reference word valid, accumulate
  } sad_state_t;

endpackage

`default_nettype wire

// ==== design/hsid_sad_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hsid_sad_unit
  import hsid_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  clear,        // Abort pixel, drop result_valid
  input  logic  sample_valid, // One cycle strobe from the APB block
  input  word_t sample,
  input  cnt_t  bands,        // Bands per pixel
  input  sad_t  det_thresh,
  input  word_t ref_word,     // FIFO data_out
  output logic  loop_en,      // One cycle loop request
  output logic  busy,
  output sad_t  result,
  output logic  result_valid,
  output logic  detect
);

  sad_state_t state;
  word_t      sample_q;   // Sample held through the fetch
  word_t      abs_diff;
  sad_t       acc;        // Running SAD for the current pixel
  sad_t       sum_next;
  cnt_t       band_cnt;   // Bands done so far
  cnt_t       band_next;
  logic       last_band;

  assign busy    = (state != SAD_IDLE);
  assign loop_en = (state == SAD_FETCH); // Word shows up in SAD_ACC

  // Absolute difference without going signed
  assign abs_diff  = (sample_q >= ref_word) ? (sample_q - ref_word) : (ref_word - sample_q);
  assign sum_next  = acc + sad_t'(abs_diff);
  assign band_next = band_cnt + 1'b1;
  assign last_band = (band_next >= bands); // Bands of 0 or 1 end every sample

  always_ff @(posedge clk) begin
    if (state == SAD_IDLE && sample_valid) begin
      sample_q <= sample;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= SAD_IDLE;
      acc          <= '0;
      band_cnt     <= '0;
      result       <= '0;
      result_valid <= 1'b0;
      detect       <= 1'b0;
    end else if (clear) begin
      state        <= SAD_IDLE; // Drops any sample in flight
      acc          <= '0;
      band_cnt     <= '0;
      result_valid <= 1'b0;
      detect       <= 1'b0;
    end else begin
      case (state)
        SAD_IDLE: begin
          if (sample_valid) begin
            state <= SAD_FETCH;
            if (band_cnt == '0) begin
              result_valid <= 1'b0; // First band of a new pixel
              detect       <= 1'b0;
            end
          end
        end
        SAD_FETCH: begin
          state <= SAD_ACC; // FIFO loops on this edge
        end
        SAD_ACC: begin
          state <= SAD_IDLE;
          if (last_band) begin
            result       <= sum_next;
            result_valid <= 1'b1;
            detect       <= (sum_next < det_thresh);
            acc          <= '0;
            band_cnt     <= '0;
          end else begin
            acc      <= sum_next;
            band_cnt <= band_next;
          end
        end
        default: begin
          state <= SAD_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/hsid_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hsid_macros.svh"

module hsid_top
  import hsid_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [7:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        full,    // Reference FIFO full
  output logic        empty,   // No spectrum loaded
  output logic        detect   // Last pixel matched
);

  word_t ref_data_in;   // APB to FIFO push data
  word_t ref_word;      // FIFO head to SAD unit
  word_t pix_sample;
  addr_t af_thresh;
  cnt_t  bands;
  sad_t  det_thresh;
  sad_t  sad_result;
  logic  ref_wr_en;
  logic  run;
  logic  clear;
  logic  almost_full;
  logic  sample_valid;
  logic  sad_busy;
  logic  sad_loop_en;
  logic  fifo_loop_en;
  logic  result_valid;

  // FIFO only recirculates in run mode
  assign fifo_loop_en = run & sad_loop_en;

  hsid_apb_regs u_apb_regs (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .paddr                 (paddr),
    .psel                  (psel),
    .penable               (penable),
    .pwrite                (pwrite),
    .pwdata                (pwdata),
    .prdata                (prdata),
    .pready                (pready),
    .pslverr               (pslverr),
    .wr_en                 (ref_wr_en),
    .data_in               (ref_data_in),
    .loop_en_run           (run),
    .clear                 (clear),
    .almost_full_threshold (af_thresh),
    .full                  (full),
    .almost_full           (almost_full),
    .empty                 (empty),
    .sample_valid          (sample_valid),
    .sample                (pix_sample),
    .bands                 (bands),
    .det_thresh            (det_thresh),
    .busy                  (sad_busy),
    .result                (sad_result),
    .result_valid          (result_valid),
    .detect                (detect)
  );

  hsid_fifo #(
    .WORD_WIDTH      (`HSID_WORD_WIDTH),
    .FIFO_ADDR_WIDTH (`HSID_FIFO_ADDR_WIDTH)
  ) u_fifo (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .loop_en               (fifo_loop_en),
    .wr_en                 (ref_wr_en),
    .rd_en                 (1'b0),        // Spectrum is never consumed
    .data_in               (ref_data_in),
    .almost_full_threshold (af_thresh),
    .data_out              (ref_word),
    .full                  (full),
    .almost_full           (almost_full),
    .empty                 (empty),
    .clear                 (clear)
  );

  hsid_sad_unit u_sad_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear        (clear),
    .sample_valid (sample_valid),
    .sample       (pix_sample),
    .bands        (bands),
    .det_thresh   (det_thresh),
    .ref_word     (ref_word),
    .loop_en      (sad_loop_en),
    .busy         (sad_busy),
    .result       (sad_result),
    .result_valid (result_valid),
    .detect       (detect)
  );

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+design
design/hsid_pkg.sv
design/hsid_fifo.sv
design/hsid_apb_regs.sv
design/hsid_sad_unit.sv
design/hsid_top.sv
tests/hsid_tb.sv

// ==== tests/hsid_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hsid_macros.svh"

module hsid_tb
  import hsid_pkg::*;
;

  localparam int CLK_PERIOD   = 100;                        // ns
  localparam int RESET_CYCLES = 16;
  localparam int MAX_WAIT     = 64;                         // Cycles or polls before giving up
  localparam int DEPTH        = 1 << `HSID_FIFO_ADDR_WIDTH; // Reference FIFO entries
  localparam int PIX_BANDS    = 8;

  logic        clk;
  logic        rst_n;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        full;
  logic        empty;
  logic        detect;

  int          seed = 32'h3642_faab;
  int          check_count;
  int          error_count;
  int          timeout_count;
  int          stall_cycles;        // Cycles spent with pready low
  bit          timed_out;           // Stops further bus traffic
  logic        last_err;
  logic [31:0] last_rdata;
  word_t       ref_q[$];            // Model of the stored spectrum
  word_t       samples[DEPTH];      // Current pixel
  int          af_thresh;
  sad_t        det_thresh;
  sad_t        exp_sad;
  logic        exp_rvalid;
  logic        exp_detect;
  int          stalls_before;

  hsid_top dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .full    (full),
    .empty   (empty),
    .detect  (detect)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (!timed_out) begin
      check_count++;
      assert (got === exp) else begin
        $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        error_count++;
      end
    end
  endtask

  // One APB transfer, entered and left 1 ns after a rising edge
  task automatic apb_xfer(input logic [7:0] addr, input logic write, input logic [31:0] wdata);
    int waits;
    waits = 0;
    if (!timed_out) begin
      paddr   = addr;  // Setup phase
      pwrite  = write;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #1 penable = 1'b1; // Access phase
      @(negedge clk);
      while (!pready && waits < MAX_WAIT) begin
        waits++;
        @(negedge clk);
      end
      if (!pready) begin
        $display("ERROR: APB access to 0x%02h never completed, pready stayed low", addr);
        timeout_count++;
        timed_out = 1'b1;
      end else begin
        stall_cycles += waits;
        last_err   = pslverr; // Sampled mid cycle
        last_rdata = prdata;
      end
      @(posedge clk); // Transfer ends here
      #1;
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    apb_xfer(addr, 1'b1, data);
    check_value("pslverr", last_err, exp_err);
  endtask

  task automatic reg_read(input logic [7:0] addr);
    apb_xfer(addr, 1'b0, 32'h0);
    check_value("pslverr", last_err, 1'b0);
  endtask

  function automatic logic [31:0] expected_status();
    logic [31:0] s;
    int          n;
    n = ref_q.size();
    s = '0;
    s[`HSID_STAT_EMPTY]  = (n == 0);
    s[`HSID_STAT_AFULL]  = (n != 0) && (n >= af_thresh); // Level reached threshold
    s[`HSID_STAT_FULL]   = (n == DEPTH);
    s[`HSID_STAT_RVALID] = exp_rvalid;
    s[`HSID_STAT_DETECT] = exp_detect;
    return s;
  endfunction

  // Sum of |sample - reference| over the first n bands
  function automatic sad_t expected_sad(input int n);
    sad_t sum;
    sum = '0;
    for (int b = 0; b < n; b++) begin
      if (samples[b] >= ref_q[b]) begin
        sum += sad_t'(samples[b] - ref_q[b]);
      end else begin
        sum += sad_t'(ref_q[b] - samples[b]);
      end
    end
    return sum;
  endfunction

  task automatic check_status();
    reg_read(`HSID_REG_STATUS);
    check_value("status", last_rdata, expected_status());
    check_value("full", full, ref_q.size() == DEPTH); // Top level flag pins
    check_value("empty", empty, ref_q.size() == 0);
  endtask

  task automatic push_ref(input word_t w);
    reg_write(`HSID_REG_REF, 32'(w), 1'b0);
    ref_q.push_back(w);
  endtask

  // Poll STATUS until the SAD result is latched
  task automatic wait_result();
    int polls;
    polls = 0;
    reg_read(`HSID_REG_STATUS);
    while (!last_rdata[`HSID_STAT_RVALID] && polls < MAX_WAIT && !timed_out) begin
      polls++;
      reg_read(`HSID_REG_STATUS);
    end
    if (!timed_out && !last_rdata[`HSID_STAT_RVALID]) begin
      $display("ERROR: result_valid never rose after the last band sample");
      timeout_count++;
      timed_out = 1'b1;
    end
  endtask

  // Back to back PIX writes, then the result and detect against the model
  task automatic run_pixel(input bit fresh);
    for (int b = 0; b < PIX_BANDS; b++) begin
      if (fresh) begin
        samples[b] = word_t'($random(seed));
      end
      reg_write(`HSID_REG_PIX, 32'(samples[b]), 1'b0);
    end
    wait_result();
    exp_sad    = expected_sad(PIX_BANDS);
    exp_rvalid = 1'b1;
    exp_detect = (exp_sad < det_thresh); // Strictly below threshold
    reg_read(`HSID_REG_RESULT);
    check_value("result", last_rdata, 32'(exp_sad));
    check_status();
    check_value("detect", detect, exp_detect);
  endtask

  initial begin
    rst_n         = 1'b0;
    paddr         = '0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    pwdata        = '0;
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    stall_cycles  = 0;
    timed_out     = 1'b0;
    af_thresh     = 0;
    det_thresh    = '0;
    exp_rvalid    = 1'b0;
    exp_detect    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;

    check_status(); // Only empty after reset
    reg_read(`HSID_REG_RESULT);
    check_value("result", last_rdata, 32'h0);
    reg_read(`HSID_REG_BANDS);
    check_value("bands", last_rdata, DEPTH);

    af_thresh = 12;
    reg_write(`HSID_REG_AF_THRESH, af_thresh, 1'b0);
    for (int i = 0; i < DEPTH; i++) begin
      push_ref(word_t'($random(seed)));
      check_status(); // almost_full at 12, full at 16
    end
    reg_write(`HSID_REG_REF, $random(seed), 1'b1); // Overflow push rejected
    check_status();

    reg_write(`HSID_REG_CTRL, 32'h1, 1'b0); // Flush
    ref_q.delete();
    check_status();

    for (int i = 0; i < PIX_BANDS; i++) begin
      push_ref(word_t'($random(seed)));
    end
    reg_write(`HSID_REG_BANDS, PIX_BANDS, 1'b0);
    det_thresh = 24'h02_a000; // Near the mean SAD of random words
    reg_write(`HSID_REG_DET_THRESH, 32'(det_thresh), 1'b0);
    reg_write(`HSID_REG_CTRL, 32'h2, 1'b0); // Run
    run_pixel(1'b1);
    run_pixel(1'b1); // Same spectrum replays in order

    det_thresh = exp_sad + 1'b1;
    reg_write(`HSID_REG_DET_THRESH, 32'(det_thresh), 1'b0);
    run_pixel(1'b0);
    check_value("detect_above", detect, 1'b1);
    det_thresh = exp_sad; // Equal is not a match
    reg_write(`HSID_REG_DET_THRESH, 32'(det_thresh), 1'b0);
    run_pixel(1'b0);
    check_value("detect_equal", detect, 1'b0);

    reg_write(`HSID_REG_REF, $random(seed), 1'b1); // No pushes while running
    check_status();

    reg_write(`HSID_REG_CTRL, 32'h1, 1'b0); // Clear and stop
    ref_q.delete();
    exp_rvalid = 1'b0;
    exp_detect = 1'b0;
    check_status();
    reg_write(`HSID_REG_PIX, $random(seed), 1'b1); // Run clear
    reg_write(`HSID_REG_CTRL, 32'h2, 1'b0);
    reg_write(`HSID_REG_PIX, $random(seed), 1'b1); // Nothing loaded
    check_status();

    reg_write(`HSID_REG_CTRL, 32'h0, 1'b0);
    for (int i = 0; i < PIX_BANDS; i++) begin
      push_ref(word_t'($random(seed)));
    end
    reg_write(`HSID_REG_CTRL, 32'h2, 1'b0);
    stalls_before = stall_cycles;
    run_pixel(1'b1);
    check_value("pix_stalled", (stall_cycles > stalls_before), 1'b1); // Back pressure seen

    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
